// File: common/pager_pkg.sv
//------------------------------
// Page geometry and entry types for the pager unit
// Shared by the page memories, the CSR block and the translator
//------------------------------
package pager_pkg;

    //------------------------------
    // Geometry
    //------------------------------
    localparam int PAGE_BITS   = 10;               // Page number width
    localparam int PAGES       = 1 << PAGE_BITS;   // 1024 pages
    localparam int OFFSET_BITS = 10;               // In-page offset width

    typedef logic [PAGE_BITS-1:0]   page_t;        // Page number
    typedef logic [OFFSET_BITS-1:0] offset_t;      // Word offset inside a page

    // Virtual address, page above offset
    typedef struct packed {
        page_t   page;                             // Virtual page
        offset_t offset;                           // Passes through untranslated
    } vaddr_t;

    // Physical address, same layout
    typedef struct packed {
        page_t   frame;                            // Physical frame
        offset_t offset;                           // Copied from the request
    } paddr_t;

    // Page map entry
    typedef struct packed {
        page_t                 frame;              // Target frame
        logic [PAGE_BITS-1:0]  rsvd;               // Stored only
    } map_entry_t;

    // Access bits of one page
    typedef struct packed {
        logic dirty;                               // Page was written
        logic used;                                // Page was referenced
    } pg_attr_t;

    typedef logic [3:0] bus_op_t;                  // Bus opcode of a request

    // Write-class opcodes: 2, 4, 10, 11, 12
    // 2 and 4 are cache writes, 10 a result store,
    // 11 read-modify-write, 12 a block transfer write
    localparam logic [15:0] DIRTY_OPS = 16'b0001_1100_0001_0100;

endpackage

// File: common/pager_regs_pkg.sv
//------------------------------
// APB register map of the pager unit
// Word offsets and CTRL bit positions
//------------------------------
package pager_regs_pkg;

    localparam int APB_ADDR_BITS = 12;             // PADDR width
    localparam int APB_DATA_BITS = 32;             // PWDATA/PRDATA width

    //------------------------------
    // Register offsets
    //------------------------------
    localparam logic [APB_ADDR_BITS-1:0] REG_CTRL       = 12'h000;  // Mode and fill control
    localparam logic [APB_ADDR_BITS-1:0] REG_PAGE_INDEX = 12'h004;  // Current page
    localparam logic [APB_ADDR_BITS-1:0] REG_MAP        = 12'h008;  // Map entry at index
    localparam logic [APB_ADDR_BITS-1:0] REG_ATTR       = 12'h00C;  // Used/dirty at index
    localparam logic [APB_ADDR_BITS-1:0] REG_REPRIO     = 12'h010;  // Reprio bit at index

    //------------------------------
    // CTRL bits
    //------------------------------
    localparam int CTRL_NO_PAGING  = 0;            // RW, bypass translation
    localparam int CTRL_FILL_START = 1;            // WO, reads 0
    localparam int CTRL_FILL_BUSY  = 2;            // RO

endpackage

// File: src/page_ram.sv
//------------------------------
// One entry per page, register array
// One synchronous write, two combinational reads
//------------------------------
`timescale 1ns/1ps

module page_ram #(
    parameter type entry_t = logic [19:0]          // Stored payload
) (
    input  logic            clk,
    input  logic            i_we,                  // Write strobe
    input  pager_pkg::page_t i_waddr,
    input  entry_t          i_wdata,
    input  pager_pkg::page_t i_raddr_a,            // Readback port
    input  pager_pkg::page_t i_raddr_b,            // Translation port
    output entry_t          o_rdata_a,
    output entry_t          o_rdata_b
);
    import pager_pkg::*;

    entry_t mem [PAGES];                           // No reset, contents undefined

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata_a = mem[i_raddr_a];             // Async read
    assign o_rdata_b = mem[i_raddr_b];

endmodule

// File: pager/pager_csr.sv
//------------------------------
// APB slave of the pager unit
// Holds the mode bit and page index, muxes readback,
// turns register writes into memory strobes
//------------------------------
`timescale 1ns/1ps

module pager_csr (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         i_psel,
    input  logic                                         i_penable,
    input  logic                                         i_pwrite,
    input  logic [pager_regs_pkg::APB_ADDR_BITS-1:0]     i_paddr,
    input  logic [pager_regs_pkg::APB_DATA_BITS-1:0]     i_pwdata,
    output logic [pager_regs_pkg::APB_DATA_BITS-1:0]     o_prdata,
    output logic                                         o_pready,
    output logic                                         o_pslverr,
    input  logic                                         i_xl_valid,
    input  logic                                         i_xl_load,
    input  pager_pkg::page_t                             i_xl_page,
    input  pager_pkg::map_entry_t                        i_map_rdata,
    input  pager_pkg::pg_attr_t                          i_attr_rdata,
    input  logic                                         i_reprio_rdata,
    input  logic                                         i_fill_busy,
    output pager_pkg::page_t                             o_page_index,
    output logic                                         o_no_paging,
    output logic                                         o_map_we,
    output pager_pkg::map_entry_t                        o_map_wdata,
    output logic                                         o_attr_we,
    output pager_pkg::pg_attr_t                          o_attr_wdata,
    output logic                                         o_reprio_we,
    output logic                                         o_reprio_wdata,
    output logic                                         o_fill_start
);
    import pager_pkg::*;
    import pager_regs_pkg::*;

    logic                     access;              // APB access phase
    logic                     addr_ok;             // Offset is mapped
    logic                     wr_err;              // Reprio write during fill
    logic                     wr_done;             // Write completes without error
    logic [APB_DATA_BITS-1:0] rdata;
    page_t                    page_index;
    logic                     no_paging;

    //------------------------------
    // Handshake
    //------------------------------
    assign access   = i_psel & i_penable;
    assign o_pready = access & ~i_xl_valid;        // Translation steals the cycle
    assign wr_err   = i_pwrite & (i_paddr == REG_REPRIO) & i_fill_busy;
    assign o_pslverr = o_pready & (~addr_ok | wr_err);
    assign wr_done  = o_pready & i_pwrite & ~o_pslverr;

    //------------------------------
    // Read mux and decode
    //------------------------------
    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (i_paddr)
            REG_CTRL: begin
                rdata[CTRL_NO_PAGING] = no_paging;
                rdata[CTRL_FILL_BUSY] = i_fill_busy; // FILL_START reads 0
            end
            REG_PAGE_INDEX: rdata = APB_DATA_BITS'(page_index);
            REG_MAP:        rdata = APB_DATA_BITS'(i_map_rdata);
            REG_ATTR:       rdata = APB_DATA_BITS'(i_attr_rdata);
            REG_REPRIO:     rdata = APB_DATA_BITS'(i_reprio_rdata);
            default:        addr_ok = 1'b0;        // Unmapped offset
        endcase
    end

    assign o_prdata = rdata;

    // Memory write strobes, all at the page index
    assign o_map_we       = wr_done & (i_paddr == REG_MAP);
    assign o_map_wdata    = map_entry_t'(i_pwdata[$bits(map_entry_t)-1:0]);
    assign o_attr_we      = wr_done & (i_paddr == REG_ATTR);
    assign o_attr_wdata   = pg_attr_t'(i_pwdata[$bits(pg_attr_t)-1:0]);
    assign o_reprio_we    = wr_done & (i_paddr == REG_REPRIO);
    assign o_reprio_wdata = i_pwdata[0];
    assign o_fill_start   = wr_done & (i_paddr == REG_CTRL) & i_pwdata[CTRL_FILL_START];

    //------------------------------
    // Registers
    //------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            page_index <= '0;
            no_paging  <= 1'b0;
        end else begin
            if (i_xl_load) begin
                page_index <= i_xl_page;           // Translation wins
            end else if (wr_done && i_paddr == REG_PAGE_INDEX) begin
                page_index <= i_pwdata[PAGE_BITS-1:0];
            end
            if (wr_done && i_paddr == REG_CTRL) begin
                no_paging <= i_pwdata[CTRL_NO_PAGING];
            end
        end
    end

    assign o_page_index = page_index;
    assign o_no_paging  = no_paging;

endmodule

// File: pager/addr_xlate.sv
//------------------------------
// Virtual to physical translation, one cycle latency
// Updates used/dirty and loads the page index per request
//------------------------------
`timescale 1ns/1ps

module addr_xlate (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_xl_valid,      // One request per cycle
    input  pager_pkg::vaddr_t     i_xl_vaddr,
    input  pager_pkg::bus_op_t    i_xl_op,
    input  logic                  i_no_paging,     // Bypass mode
    input  pager_pkg::map_entry_t i_map_entry,     // Entry of the virtual page
    input  pager_pkg::pg_attr_t   i_attr,          // Bits of the translated page
    output logic                  o_xl_valid,
    output pager_pkg::paddr_t     o_xl_paddr,
    output logic                  o_attr_we,
    output pager_pkg::page_t      o_attr_waddr,
    output pager_pkg::pg_attr_t   o_attr_wdata,
    output logic                  o_index_load,
    output pager_pkg::page_t      o_index_page
);
    import pager_pkg::*;

    page_t    xl_page;                             // Translated page
    pg_attr_t attr_next;

    assign xl_page = i_no_paging ? i_xl_vaddr.page : i_map_entry.frame;

    //------------------------------
    // Access bit update
    //------------------------------
    always_comb begin
        attr_next.used  = 1'b1;                    // Any request references the page
        attr_next.dirty = i_attr.dirty | DIRTY_OPS[i_xl_op];
    end

    assign o_attr_we    = i_xl_valid;
    assign o_attr_waddr = xl_page;
    assign o_attr_wdata = attr_next;

    // Index takes the page at the result edge
    assign o_index_load = i_xl_valid;
    assign o_index_page = xl_page;

    //------------------------------
    // Result register
    //------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_xl_valid <= 1'b0;
        end else begin
            o_xl_valid <= i_xl_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_xl_valid) begin
            o_xl_paddr.frame  <= xl_page;
            o_xl_paddr.offset <= i_xl_vaddr.offset; // Offset unchanged
        end
    end

endmodule

// File: pager/reprio_fill.sv
//------------------------------
// Reprioritize bit per page
// Bulk fill sets ones from the start index to the last page
//------------------------------
`timescale 1ns/1ps

module reprio_fill (
    input  logic             clk,
    input  logic             reset,
    input  pager_pkg::page_t i_page_index,         // Single access address
    input  logic             i_we,
    input  logic             i_wdata,
    input  logic             i_fill_start,         // One cycle pulse
    output logic             o_rdata,
    output logic             o_fill_busy
);
    import pager_pkg::*;

    logic  reprio_mem [PAGES];
    page_t fill_cnt;                               // Next page to set
    logic  fill_busy;

    //------------------------------
    // Fill sequencer
    //------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_busy <= 1'b0;
            fill_cnt  <= '0;
        end else if (fill_busy) begin
            fill_cnt <= fill_cnt + 1'b1;
            if (fill_cnt == page_t'(PAGES - 1)) begin
                fill_busy <= 1'b0;                 // Last page written
            end
        end else if (i_fill_start) begin
            fill_busy <= 1'b1;
            fill_cnt  <= i_page_index;             // Later index loads do not matter
        end
    end

    always_ff @(posedge clk) begin
        if (fill_busy) begin
            reprio_mem[fill_cnt] <= 1'b1;          // One bit per cycle
        end else if (i_we) begin
            reprio_mem[i_page_index] <= i_wdata;
        end
    end

    assign o_rdata     = reprio_mem[i_page_index];
    assign o_fill_busy = fill_busy;

endmodule

// File: pager/pager_top.sv
//------------------------------
// Pager unit top level
// APB config port plus a translation request port
//------------------------------
`timescale 1ns/1ps

module pager_top (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     i_psel,
    input  logic                                     i_penable,
    input  logic                                     i_pwrite,
    input  logic [pager_regs_pkg::APB_ADDR_BITS-1:0] i_paddr,
    input  logic [pager_regs_pkg::APB_DATA_BITS-1:0] i_pwdata,
    output logic [pager_regs_pkg::APB_DATA_BITS-1:0] o_prdata,
    output logic                                     o_pready,
    output logic                                     o_pslverr,
    input  logic                                     i_xl_valid,
    input  pager_pkg::vaddr_t                        i_xl_vaddr,
    input  pager_pkg::bus_op_t                       i_xl_op,
    output logic                                     o_xl_valid,
    output pager_pkg::paddr_t                        o_xl_paddr
);
    import pager_pkg::*;

    page_t      page_index;
    logic       no_paging;
    logic       fill_start, fill_busy;
    logic       map_we;
    map_entry_t map_wdata, map_rdata_a, map_rdata_b;
    logic       csr_attr_we, xl_attr_we, attr_we;
    pg_attr_t   csr_attr_wdata, xl_attr_wdata, attr_wdata;
    pg_attr_t   attr_rdata_a, attr_rdata_b;
    page_t      xl_attr_waddr, attr_waddr;
    logic       index_load;
    page_t      index_page;
    logic       reprio_we, reprio_wdata, reprio_rdata;

    // Attr write port belongs to the translator on a request cycle
    assign attr_we    = i_xl_valid ? xl_attr_we    : csr_attr_we;
    assign attr_waddr = i_xl_valid ? xl_attr_waddr : page_index;
    assign attr_wdata = i_xl_valid ? xl_attr_wdata : csr_attr_wdata;

    pager_csr u_csr (
        .clk(clk), .reset(reset),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .i_xl_valid(i_xl_valid), .i_xl_load(index_load), .i_xl_page(index_page),
        .i_map_rdata(map_rdata_a), .i_attr_rdata(attr_rdata_a),
        .i_reprio_rdata(reprio_rdata), .i_fill_busy(fill_busy),
        .o_page_index(page_index), .o_no_paging(no_paging),
        .o_map_we(map_we), .o_map_wdata(map_wdata),
        .o_attr_we(csr_attr_we), .o_attr_wdata(csr_attr_wdata),
        .o_reprio_we(reprio_we), .o_reprio_wdata(reprio_wdata),
        .o_fill_start(fill_start)
    );

    addr_xlate u_xlate (
        .clk(clk), .reset(reset),
        .i_xl_valid(i_xl_valid), .i_xl_vaddr(i_xl_vaddr), .i_xl_op(i_xl_op),
        .i_no_paging(no_paging),
        .i_map_entry(map_rdata_b), .i_attr(attr_rdata_b),
        .o_xl_valid(o_xl_valid), .o_xl_paddr(o_xl_paddr),
        .o_attr_we(xl_attr_we), .o_attr_waddr(xl_attr_waddr),
        .o_attr_wdata(xl_attr_wdata),
        .o_index_load(index_load), .o_index_page(index_page)
    );

    reprio_fill u_reprio (
        .clk(clk), .reset(reset),
        .i_page_index(page_index), .i_we(reprio_we), .i_wdata(reprio_wdata),
        .i_fill_start(fill_start),
        .o_rdata(reprio_rdata), .o_fill_busy(fill_busy)
    );

    page_ram #(.entry_t(map_entry_t)) map_ram (
        .clk(clk), .i_we(map_we), .i_waddr(page_index), .i_wdata(map_wdata),
        .i_raddr_a(page_index), .i_raddr_b(i_xl_vaddr.page),
        .o_rdata_a(map_rdata_a), .o_rdata_b(map_rdata_b)
    );

    // Port B reads the bits of the page being translated
    page_ram #(.entry_t(pg_attr_t)) attr_ram (
        .clk(clk), .i_we(attr_we), .i_waddr(attr_waddr), .i_wdata(attr_wdata),
        .i_raddr_a(page_index), .i_raddr_b(index_page),
        .o_rdata_a(attr_rdata_a), .o_rdata_b(attr_rdata_b)
    );

endmodule

// File: verif/pager_chk.sv
//------------------------------
// Protocol and timing assertions, bound to pager_top
//------------------------------
`timescale 1ns/1ps

module pager_chk (
    input logic clk,
    input logic reset,
    input logic i_psel,
    input logic i_penable,
    input logic i_xl_valid,
    input logic i_pready,                          // DUT o_pready
    input logic i_xl_result_valid                  // DUT o_xl_valid
);

    // Result one cycle after each request
    result_follows: assert property (@(posedge clk) disable iff (reset)
        i_xl_valid |=> i_xl_result_valid)
        else $error("Translation result missing one cycle after request");

    no_spurious_result: assert property (@(posedge clk) disable iff (reset)
        !i_xl_valid |=> !i_xl_result_valid)
        else $error("Translation result without a request");

    ready_in_access: assert property (@(posedge clk) disable iff (reset)
        i_pready |-> (i_psel && i_penable))
        else $error("PREADY high outside an access phase");

    // Translation request forces a wait state
    ready_waits: assert property (@(posedge clk) disable iff (reset)
        (i_psel && i_penable && i_xl_valid) |-> !i_pready)
        else $error("PREADY high during a translation request");

endmodule

bind pager_top pager_chk u_chk (
    .clk(clk), .reset(reset),
    .i_psel(i_psel), .i_penable(i_penable), .i_xl_valid(i_xl_valid),
    .i_pready(o_pready), .i_xl_result_valid(o_xl_valid)
);

// File: verif/tb_pager.sv
//------------------------------
// Directed testbench for the pager unit
// Covers APB register access, translation, used/dirty,
// the reprio fill, wait states and slave errors
//------------------------------
`timescale 1ns/1ps

module tb_pager;
    import pager_regs_pkg::*;

    localparam int         MAX_CYCLES = 4000;      // Tests plus a full 1024-page fill
    localparam int         NUM_MAPS   = 8;         // Random map entries
    localparam logic [9:0] TGT_PAGE   = 10'd7;     // Virtual page for access bit tests
    localparam logic [9:0] TGT_FRAME  = 10'h2A5;   // Its frame

    logic        clk;
    logic        reset;
    logic        psel, penable, pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;
    logic        xl_valid, xl_valid_out;
    logic [19:0] xl_vaddr, xl_paddr;
    logic [3:0]  xl_op;

    int          seed   = 32'h2f55;
    int          cycles = 0;
    logic [19:0] map_model [1024];                 // Expected map contents
    logic [9:0]  map_pages [NUM_MAPS];

    pager_top uut (
        .clk(clk), .reset(reset),
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata),
        .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
        .i_xl_valid(xl_valid), .i_xl_vaddr(xl_vaddr), .i_xl_op(xl_op),
        .o_xl_valid(xl_valid_out), .o_xl_paddr(xl_paddr)
    );

    always #2 clk = ~clk;                          // 4 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $fatal(1, "Simulation timed out");
        end
    end

    //------------------------------
    // Helpers
    //------------------------------
    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Write-class bus opcodes set the dirty bit
    function automatic logic is_write_op(input logic [3:0] op);
        return (op == 4'd2) || (op == 4'd4) || (op == 4'd10) ||
               (op == 4'd11) || (op == 4'd12);
    endfunction

    task automatic apb_xfer(input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;                            // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;                            // Access phase
        #1;
        while (!pready) begin                      // Wait states
            @(negedge clk);
            #1;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);                            // Completed at the posedge
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check("o_pslverr", {31'b0, err}, {31'b0, exp_err});
    endtask

    task automatic apb_read(input logic [11:0] addr, input logic exp_err,
                            output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'h0, data, err);
        check("o_pslverr", {31'b0, err}, {31'b0, exp_err});
    endtask

    task automatic read_expect(input logic [11:0] addr, input string name,
                               input logic [31:0] expected);
        logic [31:0] data;
        apb_read(addr, 1'b0, data);
        check(name, data, expected);
    endtask

    // One request, result checked one cycle later
    task automatic translate(input logic [19:0] vaddr, input logic [3:0] op,
                             input logic [19:0] exp_paddr);
        @(negedge clk);
        xl_valid = 1'b1;
        xl_vaddr = vaddr;
        xl_op    = op;
        @(negedge clk);
        xl_valid = 1'b0;
        check("o_xl_valid", {31'b0, xl_valid_out}, 32'd1);
        check("o_xl_paddr", {12'b0, xl_paddr}, {12'b0, exp_paddr});
    endtask

    //------------------------------
    // Tests
    //------------------------------
    task automatic mapped_translation();
        logic [31:0] rnd;
        for (int i = 0; i < NUM_MAPS; i++) begin
            rnd = $random(seed);
            map_pages[i] = rnd[9:0];
            rnd = $random(seed);
            map_model[map_pages[i]] = rnd[19:0];
            apb_write(REG_PAGE_INDEX, {22'b0, map_pages[i]}, 1'b0);
            apb_write(REG_MAP, {12'b0, rnd[19:0]}, 1'b0);
            read_expect(REG_MAP, "REG_MAP", {12'b0, rnd[19:0]});
        end
        for (int i = 0; i < NUM_MAPS; i++) begin
            rnd = $random(seed);                   // Random offset
            translate({map_pages[i], rnd[9:0]}, 4'd0,
                      {map_model[map_pages[i]][19:10], rnd[9:0]});
        end
    endtask

    task automatic bypass_mode();
        logic [31:0] rnd;
        apb_write(REG_CTRL, 32'h1, 1'b0);          // no_paging on
        read_expect(REG_CTRL, "REG_CTRL", 32'h1);
        rnd = $random(seed);
        translate(rnd[19:0], 4'd0, rnd[19:0]);     // Address passes through
        apb_write(REG_CTRL, 32'h0, 1'b0);
        read_expect(REG_CTRL, "REG_CTRL", 32'h0);
    endtask

    task automatic access_bits();
        logic exp_dirty;
        map_model[TGT_PAGE] = {TGT_FRAME, 10'h0};
        apb_write(REG_PAGE_INDEX, {22'b0, TGT_PAGE}, 1'b0);
        apb_write(REG_MAP, {12'b0, TGT_FRAME, 10'h0}, 1'b0);
        apb_write(REG_PAGE_INDEX, {22'b0, TGT_FRAME}, 1'b0);
        apb_write(REG_ATTR, 32'h0, 1'b0);          // Clear used and dirty
        read_expect(REG_ATTR, "REG_ATTR", 32'h0);
        apb_write(REG_PAGE_INDEX, 32'h0, 1'b0);    // Move away, translation reloads it
        exp_dirty = is_write_op(4'd1);             // Read-class
        translate({TGT_PAGE, 10'h155}, 4'd1, {TGT_FRAME, 10'h155});
        read_expect(REG_PAGE_INDEX, "REG_PAGE_INDEX", {22'b0, TGT_FRAME});
        read_expect(REG_ATTR, "REG_ATTR", {30'b0, exp_dirty, 1'b1});
        exp_dirty = exp_dirty | is_write_op(4'd10);
        translate({TGT_PAGE, 10'h0AA}, 4'd10, {TGT_FRAME, 10'h0AA});
        read_expect(REG_ATTR, "REG_ATTR", {30'b0, exp_dirty, 1'b1});
    endtask

    task automatic reprio_fill_run();
        logic [31:0] rdata;
        apb_write(REG_PAGE_INDEX, 32'd5, 1'b0);
        apb_write(REG_REPRIO, 32'd0, 1'b0);
        read_expect(REG_REPRIO, "REG_REPRIO", 32'd0);
        apb_write(REG_PAGE_INDEX, 32'd300, 1'b0);
        apb_write(REG_REPRIO, 32'd0, 1'b0);
        read_expect(REG_REPRIO, "REG_REPRIO", 32'd0);
        apb_write(REG_PAGE_INDEX, 32'd100, 1'b0);  // Fill start page
        apb_write(REG_CTRL, 32'h2, 1'b0);          // FILL_START
        read_expect(REG_CTRL, "REG_CTRL", 32'h4);  // Busy, start bit reads 0
        // Index moves during the fill, range stays 100..1023
        translate({TGT_PAGE, 10'h0}, 4'd0, {TGT_FRAME, 10'h0});
        apb_write(REG_PAGE_INDEX, 32'd5, 1'b0);
        apb_write(REG_REPRIO, 32'd1, 1'b1);        // Rejected while busy
        apb_read(REG_CTRL, 1'b0, rdata);
        while (rdata[CTRL_FILL_BUSY]) begin
            apb_read(REG_CTRL, 1'b0, rdata);
        end
        read_expect(REG_REPRIO, "REG_REPRIO", 32'd0);  // Page 5 untouched
        apb_write(REG_PAGE_INDEX, 32'd300, 1'b0);
        read_expect(REG_REPRIO, "REG_REPRIO", 32'd1);
        apb_write(REG_PAGE_INDEX, 32'd1023, 1'b0);
        read_expect(REG_REPRIO, "REG_REPRIO", 32'd1);  // Last page
    endtask

    task automatic contention_and_errors();
        logic [31:0] rdata;
        apb_write(REG_CTRL, 32'h1, 1'b0);          // Bypass keeps the index at TGT_PAGE
        apb_write(REG_PAGE_INDEX, {22'b0, TGT_PAGE}, 1'b0);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = REG_MAP;
        @(negedge clk);
        penable  = 1'b1;
        xl_valid = 1'b1;                           // Request in the access cycle
        xl_vaddr = {TGT_PAGE, 10'h03C};
        xl_op    = 4'd0;
        repeat (2) begin
            #1;
            check("o_pready", {31'b0, pready}, 32'd0);
            @(negedge clk);
        end
        xl_valid = 1'b0;
        #1;
        check("o_pready", {31'b0, pready}, 32'd1);
        check("o_prdata", prdata, {12'b0, map_model[TGT_PAGE]});
        check("o_pslverr", {31'b0, pslverr}, 32'd0);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        apb_write(REG_CTRL, 32'h0, 1'b0);
        apb_read(12'h020, 1'b1, rdata);            // Unmapped offset
        apb_write(12'h020, 32'hFFFF_FFFF, 1'b1);
    endtask

    //------------------------------
    // Main sequence
    //------------------------------
    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = 12'h0;
        pwdata   = 32'h0;
        xl_valid = 1'b0;
        xl_vaddr = 20'h0;
        xl_op    = 4'd0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        mapped_translation();
        bypass_mode();
        access_bits();
        reprio_fill_run();
        contention_and_errors();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: filelist.f
common/pager_pkg.sv
common/pager_regs_pkg.sv
src/page_ram.sv
pager/pager_csr.sv
pager/addr_xlate.sv
pager/reprio_fill.sv
pager/pager_top.sv
verif/pager_chk.sv
verif/tb_pager.sv

// File: Makefile
SRCS := $(shell grep -v '^+' filelist.f)

obj_dir/Vtb_pager: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_pager -f filelist.f -o Vtb_pager

run: obj_dir/Vtb_pager
	./obj_dir/Vtb_pager

clean:
	rm -rf obj_dir

.PHONY: run clean
